// File: Makefile
VERILATOR  = verilator
TOP        = tb_vga_screen
FILELIST   = sim.f
OBJ_DIR    = obj_dir
SIM_FLAGS  = --binary --timing -Wno-fatal --Mdir $(OBJ_DIR)
LINT_FLAGS = --lint-only --timing
PASS_MSG   = ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: design/palette_rom.sv
`timescale 1ns/10ps
`default_nettype none

module palette_rom (
	input  wire                                 iVGA_CLK,
	input  wire                                 iRST_n,
	input  wire screen_layout_pkg::pal_index_t  pix_index,
	output vga_timing_pkg::rgb_t                pix_rgb
);

	import vga_timing_pkg::*;
	import screen_layout_pkg::*;

	rgb_t lut_rgb;

	// house order within each group follows house_t
	always_comb
	begin
		case (pix_index)
			pal_black:             lut_rgb = 24'h000000;
			pal_white:             lut_rgb = 24'hFFFFFF;
			pal_gray:              lut_rgb = 24'h808080;
			pal_bg_base:           lut_rgb = 24'h7F0000;
			pal_bg_base + 4'd1:    lut_rgb = 24'h005F00;
			pal_bg_base + 4'd2:    lut_rgb = 24'hC0A000;
			pal_bg_base + 4'd3:    lut_rgb = 24'h00007F;
			pal_crest_base:        lut_rgb = 24'hFF4040;
			pal_crest_base + 4'd1: lut_rgb = 24'h40C040;
			pal_crest_base + 4'd2: lut_rgb = 24'hFFE040;
			pal_crest_base + 4'd3: lut_rgb = 24'h4040FF;
			// spare entries
			default:               lut_rgb = 24'h000000;
		endcase
	end

	always_ff @(posedge iVGA_CLK or negedge iRST_n)
	begin
		if (!iRST_n)
			pix_rgb <= '0;
		else
			pix_rgb <= lut_rgb;
	end

endmodule

`default_nettype wire

// File: design/pixel_painter.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_painter (
	input  wire                                      iVGA_CLK,
	input  wire                                      iRST_n,
	input  wire vga_timing_pkg::hcount_t             h_count,
	input  wire vga_timing_pkg::vcount_t             v_count,
	input  wire                                      blank_raw,
	input  wire                                      frame_two_player,
	input  wire screen_layout_pkg::house_t           frame_house_p1,
	input  wire screen_layout_pkg::house_t           frame_house_p2,
	input  wire screen_layout_pkg::bcd_digit_t [3:0] frame_p1_digits,
	input  wire screen_layout_pkg::bcd_digit_t [2:0] frame_p2_digits,
	output screen_layout_pkg::pal_index_t            pix_index
);

	import vga_timing_pkg::*;
	import screen_layout_pkg::*;

	// segments a..g from msb down
	function automatic logic [6:0] seg_pattern(bcd_digit_t d);
		case (d)
			4'd0:    return 7'b1111110;
			4'd1:    return 7'b0110000;
			4'd2:    return 7'b1101101;
			4'd3:    return 7'b1111001;
			4'd4:    return 7'b0110011;
			4'd5:    return 7'b1011011;
			4'd6:    return 7'b1011111;
			4'd7:    return 7'b1110000;
			4'd8:    return 7'b1111111;
			4'd9:    return 7'b1111011;
			default: return 7'b0000000;
		endcase
	endfunction

	function automatic logic in_rect(
		logic [4:0] x, logic [4:0] y,
		logic [4:0] x0, logic [4:0] x1,
		logic [4:0] y0, logic [4:0] y1
	);
		return (x >= x0) && (x <= x1) && (y >= y0) && (y <= y1);
	endfunction

	logic [0:9]  fld_on;
	hcount_t     fld_start [10];
	bcd_digit_t  fld_digit [10];
	logic        field_hit;
	hcount_t     field_start;
	bcd_digit_t  field_digit;
	logic [4:0]  cell_col;
	logic [4:0]  cell_row;
	logic [6:0]  seg_area;
	logic        seg_lit;
	logic        crest_p1_hit;
	logic        crest_p2_hit;
	logic        trace_hit;
	pal_index_t  next_index;

	//////////////////////////////////////////////////
	// digit fields, one-player set then two-player set
	//////////////////////////////////////////////////

	assign fld_on    = {{4{!frame_two_player}}, {6{frame_two_player}}};
	assign fld_start = '{op_thousands_col, op_hundreds_col, op_tens_col, op_ones_col,
		tp_p1_hundreds_col, tp_p1_tens_col, tp_p1_ones_col,
		tp_p2_hundreds_col, tp_p2_tens_col, tp_p2_ones_col};
	assign fld_digit = '{frame_p1_digits[3], frame_p1_digits[2], frame_p1_digits[1],
		frame_p1_digits[0], frame_p1_digits[2], frame_p1_digits[1], frame_p1_digits[0],
		frame_p2_digits[2], frame_p2_digits[1], frame_p2_digits[0]};

	// active fields never overlap
	always_comb
	begin
		field_hit   = 1'b0;
		field_start = '0;
		field_digit = '0;
		for (int k = 0; k < 10; k++)
		begin
			if (fld_on[k] && (v_count < digit_band_rows) && (h_count >= fld_start[k])
				&& (h_count < fld_start[k] + digit_field_width))
			begin
				field_hit   = 1'b1;
				field_start = fld_start[k];
				field_digit = fld_digit[k];
			end
		end
	end

	// position inside the 30x30 cell
	assign cell_col = 5'(h_count - field_start);
	assign cell_row = 5'(v_count);

	assign seg_area[6] = in_rect(cell_col, cell_row, 5'd8, 5'd21, 5'd2, 5'd4);
	assign seg_area[5] = in_rect(cell_col, cell_row, 5'd21, 5'd23, 5'd2, 5'd15);
	assign seg_area[4] = in_rect(cell_col, cell_row, 5'd21, 5'd23, 5'd13, 5'd27);
	assign seg_area[3] = in_rect(cell_col, cell_row, 5'd8, 5'd21, 5'd25, 5'd27);
	assign seg_area[2] = in_rect(cell_col, cell_row, 5'd6, 5'd8, 5'd13, 5'd27);
	assign seg_area[1] = in_rect(cell_col, cell_row, 5'd6, 5'd8, 5'd2, 5'd15);
	assign seg_area[0] = in_rect(cell_col, cell_row, 5'd8, 5'd21, 5'd13, 5'd15);

	assign seg_lit = field_hit && (|(seg_area & seg_pattern(field_digit)));

	//////////////////////////////////////////////////
	// crests, trace box and priority
	//////////////////////////////////////////////////

	assign crest_p1_hit = (v_count >= crest_row_first) && (v_count <= crest_row_last)
		&& (h_count >= crest_p1_col_first) && (h_count <= crest_p1_col_last);
	assign crest_p2_hit = frame_two_player
		&& (v_count >= crest_row_first) && (v_count <= crest_row_last)
		&& (h_count >= crest_p2_col_first) && (h_count <= crest_p2_col_last);
	assign trace_hit = (v_count >= trace_row_first) && (v_count <= trace_row_last)
		&& (h_count >= trace_col_first) && (h_count <= trace_col_last);

	always_comb
	begin
		if (!blank_raw)
			next_index = pal_black;
		else if (seg_lit)
			next_index = pal_white;
		else if (crest_p1_hit)
			next_index = pal_crest_base + pal_index_t'(frame_house_p1);
		else if (crest_p2_hit)
			next_index = pal_crest_base + pal_index_t'(frame_house_p2);
		else if (trace_hit)
			next_index = pal_gray;
		else
			next_index = pal_bg_base + pal_index_t'(frame_house_p1);
	end

	always_ff @(posedge iVGA_CLK or negedge iRST_n)
	begin
		if (!iRST_n)
			pix_index <= pal_black;
		else
			pix_index <= next_index;
	end

endmodule

`default_nettype wire

// File: design/screen_config_regs.sv
`timescale 1ns/10ps
`default_nettype none

module screen_config_regs (
	input  wire                                      iVGA_CLK,
	input  wire                                      iRST_n,
	input  wire                                      frame_end,
	input  wire                                      two_player_mode,
	input  wire screen_layout_pkg::house_t           house_p1,
	input  wire screen_layout_pkg::house_t           house_p2,
	input  wire screen_layout_pkg::bcd_digit_t       p1_thousands,
	input  wire screen_layout_pkg::bcd_digit_t       p1_hundreds,
	input  wire screen_layout_pkg::bcd_digit_t       p1_tens,
	input  wire screen_layout_pkg::bcd_digit_t       p1_ones,
	input  wire screen_layout_pkg::bcd_digit_t       p2_hundreds,
	input  wire screen_layout_pkg::bcd_digit_t       p2_tens,
	input  wire screen_layout_pkg::bcd_digit_t       p2_ones,
	output logic                                     frame_two_player,
	output screen_layout_pkg::house_t                frame_house_p1,
	output screen_layout_pkg::house_t                frame_house_p2,
	output screen_layout_pkg::bcd_digit_t [3:0]      frame_p1_digits,
	output screen_layout_pkg::bcd_digit_t [2:0]      frame_p2_digits
);

	import screen_layout_pkg::*;

	// settings only move on the last pixel of a frame
	// so the painter sees one set from (0,0) onwards
	always_ff @(posedge iVGA_CLK or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			frame_two_player <= 1'b0;
			frame_house_p1   <= gryffindor;
			frame_house_p2   <= gryffindor;
			frame_p1_digits  <= '0;
			frame_p2_digits  <= '0;
		end
		else if (frame_end)
		begin
			frame_two_player <= two_player_mode;
			frame_house_p1   <= house_p1;
			frame_house_p2   <= house_p2;
			// most significant digit in the top slot
			frame_p1_digits  <= {p1_thousands, p1_hundreds, p1_tens, p1_ones};
			frame_p2_digits  <= {p2_hundreds, p2_tens, p2_ones};
		end
	end

endmodule

`default_nettype wire

// File: design/screen_layout_pkg.sv
`default_nettype none

package screen_layout_pkg;

	//////////////////////////////////////////////////
	// game setting types
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {
		gryffindor = 2'd0,
		slytherin  = 2'd1,
		hufflepuff = 2'd2,
		ravenclaw  = 2'd3
	} house_t;

	typedef logic [3:0] pal_index_t;
	typedef logic [3:0] bcd_digit_t;

	// fixed colours, then one entry per house from each base
	localparam pal_index_t pal_black      = 4'd0;
	localparam pal_index_t pal_white      = 4'd1;
	localparam pal_index_t pal_gray       = 4'd2;
	localparam pal_index_t pal_bg_base    = 4'd3;
	localparam pal_index_t pal_crest_base = 4'd7;

	//////////////////////////////////////////////////
	// screen regions, bounds inclusive
	//////////////////////////////////////////////////

	localparam vga_timing_pkg::vcount_t trace_row_first = 10'd40;
	localparam vga_timing_pkg::vcount_t trace_row_last  = 10'd439;
	localparam vga_timing_pkg::hcount_t trace_col_first = 10'd120;
	localparam vga_timing_pkg::hcount_t trace_col_last  = 10'd519;

	localparam vga_timing_pkg::vcount_t crest_row_first    = 10'd10;
	localparam vga_timing_pkg::vcount_t crest_row_last     = 10'd109;
	localparam vga_timing_pkg::hcount_t crest_p1_col_first = 10'd10;
	localparam vga_timing_pkg::hcount_t crest_p1_col_last  = 10'd109;
	localparam vga_timing_pkg::hcount_t crest_p2_col_first = 10'd530;
	localparam vga_timing_pkg::hcount_t crest_p2_col_last  = 10'd629;

	// score digits sit in a band at the top of the screen
	localparam vga_timing_pkg::vcount_t digit_band_rows   = 10'd30;
	localparam vga_timing_pkg::hcount_t digit_field_width = 10'd30;

	// one-player field starts
	localparam vga_timing_pkg::hcount_t op_thousands_col = 10'd520;
	localparam vga_timing_pkg::hcount_t op_hundreds_col  = 10'd550;
	localparam vga_timing_pkg::hcount_t op_tens_col      = 10'd580;
	localparam vga_timing_pkg::hcount_t op_ones_col      = 10'd610;

	// two-player field starts
	localparam vga_timing_pkg::hcount_t tp_p1_hundreds_col = 10'd120;
	localparam vga_timing_pkg::hcount_t tp_p1_tens_col     = 10'd150;
	localparam vga_timing_pkg::hcount_t tp_p1_ones_col     = 10'd180;
	localparam vga_timing_pkg::hcount_t tp_p2_hundreds_col = 10'd430;
	localparam vga_timing_pkg::hcount_t tp_p2_tens_col     = 10'd460;
	localparam vga_timing_pkg::hcount_t tp_p2_ones_col     = 10'd490;

endpackage

`default_nettype wire

// File: design/vga_screen_top.sv
`timescale 1ns/10ps
`default_nettype none

module vga_screen_top (
	input  wire                                 iVGA_CLK,
	input  wire                                 iRST_n,
	input  wire                                 two_player_mode,
	input  wire screen_layout_pkg::house_t      house_p1,
	input  wire screen_layout_pkg::house_t      house_p2,
	input  wire screen_layout_pkg::bcd_digit_t  p1_thousands,
	input  wire screen_layout_pkg::bcd_digit_t  p1_hundreds,
	input  wire screen_layout_pkg::bcd_digit_t  p1_tens,
	input  wire screen_layout_pkg::bcd_digit_t  p1_ones,
	input  wire screen_layout_pkg::bcd_digit_t  p2_hundreds,
	input  wire screen_layout_pkg::bcd_digit_t  p2_tens,
	input  wire screen_layout_pkg::bcd_digit_t  p2_ones,
	output logic                                oBLANK_n,
	output logic                                oHS,
	output logic                                oVS,
	output logic [7:0]                          r_data,
	output logic [7:0]                          g_data,
	output logic [7:0]                          b_data
);

	import vga_timing_pkg::*;
	import screen_layout_pkg::*;

	hcount_t          h_count;
	vcount_t          v_count;
	logic             hs_raw;
	logic             vs_raw;
	logic             blank_raw;
	logic             frame_end;
	logic             frame_two_player;
	house_t           frame_house_p1;
	house_t           frame_house_p2;
	bcd_digit_t [3:0] frame_p1_digits;
	bcd_digit_t [2:0] frame_p2_digits;
	pal_index_t       pix_index;
	rgb_t             pix_rgb;
	logic [1:0]       hs_pipe;
	logic [1:0]       vs_pipe;
	logic [1:0]       blank_pipe;

	video_sync_gen u_sync (
		.iVGA_CLK  (iVGA_CLK),
		.iRST_n    (iRST_n),
		.h_count   (h_count),
		.v_count   (v_count),
		.hs_raw    (hs_raw),
		.vs_raw    (vs_raw),
		.blank_raw (blank_raw),
		.frame_end (frame_end)
	);

	screen_config_regs u_config (
		.iVGA_CLK         (iVGA_CLK),
		.iRST_n           (iRST_n),
		.frame_end        (frame_end),
		.two_player_mode  (two_player_mode),
		.house_p1         (house_p1),
		.house_p2         (house_p2),
		.p1_thousands     (p1_thousands),
		.p1_hundreds      (p1_hundreds),
		.p1_tens          (p1_tens),
		.p1_ones          (p1_ones),
		.p2_hundreds      (p2_hundreds),
		.p2_tens          (p2_tens),
		.p2_ones          (p2_ones),
		.frame_two_player (frame_two_player),
		.frame_house_p1   (frame_house_p1),
		.frame_house_p2   (frame_house_p2),
		.frame_p1_digits  (frame_p1_digits),
		.frame_p2_digits  (frame_p2_digits)
	);

	pixel_painter u_painter (
		.iVGA_CLK         (iVGA_CLK),
		.iRST_n           (iRST_n),
		.h_count          (h_count),
		.v_count          (v_count),
		.blank_raw        (blank_raw),
		.frame_two_player (frame_two_player),
		.frame_house_p1   (frame_house_p1),
		.frame_house_p2   (frame_house_p2),
		.frame_p1_digits  (frame_p1_digits),
		.frame_p2_digits  (frame_p2_digits),
		.pix_index        (pix_index)
	);

	palette_rom u_palette (
		.iVGA_CLK  (iVGA_CLK),
		.iRST_n    (iRST_n),
		.pix_index (pix_index),
		.pix_rgb   (pix_rgb)
	);

	//////////////////////////////////////////////////
	// sync delay, matches painter plus palette
	//////////////////////////////////////////////////

	always_ff @(posedge iVGA_CLK or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			// syncs idle high, display blanked
			hs_pipe    <= 2'b11;
			vs_pipe    <= 2'b11;
			blank_pipe <= 2'b00;
		end
		else
		begin
			hs_pipe    <= {hs_pipe[0], hs_raw};
			vs_pipe    <= {vs_pipe[0], vs_raw};
			blank_pipe <= {blank_pipe[0], blank_raw};
		end
	end

	assign oHS      = hs_pipe[1];
	assign oVS      = vs_pipe[1];
	assign oBLANK_n = blank_pipe[1];

	assign r_data = pix_rgb[23:16];
	assign g_data = pix_rgb[15:8];
	assign b_data = pix_rgb[7:0];

endmodule

`default_nettype wire

// File: design/vga_timing_pkg.sv
`default_nettype none

package vga_timing_pkg;

	//////////////////////////////////////////////////
	// raster coordinate and colour types
	//////////////////////////////////////////////////

	// wide enough for the 800 and 525 totals
	typedef logic [9:0] hcount_t;
	typedef logic [9:0] vcount_t;

	// red [23:16], green [15:8], blue [7:0]
	typedef logic [23:0] rgb_t;

	//////////////////////////////////////////////////
	// 640x480 at 60 Hz raster
	//////////////////////////////////////////////////

	// horizontal, in pixel clocks
	localparam hcount_t h_visible    = 10'd640;
	localparam hcount_t h_sync_start = 10'd656;
	localparam hcount_t h_sync_end   = 10'd752;
	localparam hcount_t h_total      = 10'd800;

	// vertical, in lines
	localparam vcount_t v_visible    = 10'd480;
	localparam vcount_t v_sync_start = 10'd490;
	localparam vcount_t v_sync_end   = 10'd492;
	localparam vcount_t v_total      = 10'd525;

endpackage

`default_nettype wire

// File: design/video_sync_gen.sv
`timescale 1ns/10ps
`default_nettype none

module video_sync_gen (
	input  wire                     iVGA_CLK,
	input  wire                     iRST_n,
	output vga_timing_pkg::hcount_t h_count,
	output vga_timing_pkg::vcount_t v_count,
	output logic                    hs_raw,
	output logic                    vs_raw,
	output logic                    blank_raw,
	output logic                    frame_end
);

	import vga_timing_pkg::*;

	logic line_end;
	logic last_line;

	assign line_end  = (h_count == h_total - 10'd1);
	assign last_line = (v_count == v_total - 10'd1);

	//////////////////////////////////////////////////
	// free running raster counters
	//////////////////////////////////////////////////

	always_ff @(posedge iVGA_CLK or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			h_count <= '0;
			v_count <= '0;
		end
		else
		begin
			if (line_end)
			begin
				h_count <= '0;
				// next line, or back to the top
				if (last_line)
					v_count <= '0;
				else
					v_count <= v_count + 10'd1;
			end
			else
				h_count <= h_count + 10'd1;
		end
	end

	//////////////////////////////////////////////////
	// decode from counters
	//////////////////////////////////////////////////

	// both syncs are active low
	assign hs_raw = !((h_count >= h_sync_start) && (h_count < h_sync_end));
	assign vs_raw = !((v_count >= v_sync_start) && (v_count < v_sync_end));

	// high inside the visible area
	assign blank_raw = (h_count < h_visible) && (v_count < v_visible);

	// last pixel of the last line
	assign frame_end = line_end && last_line;

endmodule

`default_nettype wire

// File: sim.f
design/vga_timing_pkg.sv
design/screen_layout_pkg.sv
design/video_sync_gen.sv
design/screen_config_regs.sv
design/pixel_painter.sv
design/palette_rom.sv
design/vga_screen_top.sv
test/tb_vga_screen.sv

// File: test/screen_testdata.txt
# S two_player house_p1 house_p2 p1_thousands p1_hundreds p1_tens p1_ones p2_hundreds p2_tens p2_ones
# P column row expected_rgb_hex (belongs to the S line above it)
S 0 2 1 8 1 12 0 5 5 5
P 300 460 C0A000
P 300 200 808080
P 50 50 FFE040
P 530 3 FFFFFF
P 535 8 C0A000
P 572 8 FFFFFF
P 565 3 C0A000
P 595 14 C0A000
P 617 8 FFFFFF
P 625 14 C0A000
S 1 0 3 9 4 7 2 3 6 9
P 580 60 4040FF
P 50 50 FF4040
P 530 3 7F0000
P 127 8 FFFFFF
P 135 3 7F0000
P 165 3 FFFFFF
P 187 20 FFFFFF
P 202 20 7F0000
P 445 14 FFFFFF
P 482 8 7F0000
P 497 8 FFFFFF
P 300 300 808080
P 600 460 7F0000

// File: test/tb_vga_screen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_vga_screen;

	import vga_timing_pkg::*;
	import screen_layout_pkg::*;

	localparam int frame_cycles = 800 * 525;
	localparam int max_frames   = 6;

	logic       iVGA_CLK;
	logic       iRST_n;
	logic       two_player_mode;
	house_t     house_p1;
	house_t     house_p2;
	bcd_digit_t p1_thousands;
	bcd_digit_t p1_hundreds;
	bcd_digit_t p1_tens;
	bcd_digit_t p1_ones;
	bcd_digit_t p2_hundreds;
	bcd_digit_t p2_tens;
	bcd_digit_t p2_ones;
	wire        oBLANK_n;
	wire        oHS;
	wire        oVS;
	wire [7:0]  r_data;
	wire [7:0]  g_data;
	wire [7:0]  b_data;

	int   err_value;
	int   err_other;
	// settings driven for the next frame and those of the frame on screen
	int   pend_scn;
	int   pend_two;
	int   pend_h1;
	int   pend_h2;
	int   pend_p1 [4];
	int   pend_p2 [3];
	int   cur_scn;
	int   m_two;
	int   m_h1;
	int   m_h2;
	int   m_p1 [4];
	int   m_p2 [3];
	// data file contents
	int   sc_val [4][10];
	int   n_scn;
	int   p_scn [$];
	int   p_col [$];
	int   p_row [$];
	rgb_t p_rgb [$];
	bit   p_seen [$];
	int   probe_hits;
	// port-side raster tracking
	int   mon_col;
	int   mon_row;
	bit   new_frame;
	logic blank_prev;
	logic hs_prev;
	logic vs_prev;
	int   hs_run;
	int   hs_gap;
	int   frames_seen;
	int   fc_cycles;
	int   fc_hs_low;
	int   fc_vs_low;
	int   fc_blank;
	rgb_t pix;

	vga_screen_top u_dut (
		.iVGA_CLK        (iVGA_CLK),
		.iRST_n          (iRST_n),
		.two_player_mode (two_player_mode),
		.house_p1        (house_p1),
		.house_p2        (house_p2),
		.p1_thousands    (p1_thousands),
		.p1_hundreds     (p1_hundreds),
		.p1_tens         (p1_tens),
		.p1_ones         (p1_ones),
		.p2_hundreds     (p2_hundreds),
		.p2_tens         (p2_tens),
		.p2_ones         (p2_ones),
		.oBLANK_n        (oBLANK_n),
		.oHS             (oHS),
		.oVS             (oVS),
		.r_data          (r_data),
		.g_data          (g_data),
		.b_data          (b_data)
	);

	always #50 iVGA_CLK = ~iVGA_CLK;

	//////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////

	task automatic check_rgb(rgb_t got, rgb_t exp, string msg);
		if (got !== exp)
		begin
			err_value++;
			$display("CHECK FAILED at %0d ns: %s, got %06h expected %06h", $time, msg, got, exp);
		end
	endtask

	task automatic check_level(logic got, logic exp, string msg);
		if (got !== exp)
		begin
			err_value++;
			$display("CHECK FAILED at %0d ns: %s, got %b expected %b", $time, msg, got, exp);
		end
	endtask

	task automatic check_count(int got, int exp, string msg);
		if (got != exp)
		begin
			err_value++;
			$display("CHECK FAILED at %0d ns: %s, got %0d expected %0d", $time, msg, got, exp);
		end
	endtask

	//////////////////////////////////////////////////
	// screen model
	//////////////////////////////////////////////////

	function automatic bit in_box(int x, int y, int x0, int x1, int y0, int y1);
		return (x >= x0) && (x <= x1) && (y >= y0) && (y <= y1);
	endfunction

	// each segment listed with the digits that leave it dark
	function automatic bit seg_hit(int d, int x, int y);
		bit lit;
		lit = 0;
		if (d > 9)
			return 0;
		if (in_box(x, y, 8, 21, 2, 4) && d != 1 && d != 4)
			lit = 1;
		if (in_box(x, y, 21, 23, 2, 15) && d != 5 && d != 6)
			lit = 1;
		if (in_box(x, y, 21, 23, 13, 27) && d != 2)
			lit = 1;
		if (in_box(x, y, 8, 21, 25, 27) && d != 1 && d != 4 && d != 7)
			lit = 1;
		if (in_box(x, y, 6, 8, 13, 27) && (d == 0 || d == 2 || d == 6 || d == 8))
			lit = 1;
		if (in_box(x, y, 6, 8, 2, 15) && d != 1 && d != 2 && d != 3 && d != 7)
			lit = 1;
		if (in_box(x, y, 8, 21, 13, 15) && d != 0 && d != 1 && d != 7)
			lit = 1;
		return lit;
	endfunction

	function automatic rgb_t bg_rgb(int h);
		case (h)
			0:       return 24'h7F0000;
			1:       return 24'h005F00;
			2:       return 24'hC0A000;
			default: return 24'h00007F;
		endcase
	endfunction

	function automatic rgb_t crest_rgb(int h);
		case (h)
			0:       return 24'hFF4040;
			1:       return 24'h40C040;
			2:       return 24'hFFE040;
			default: return 24'h4040FF;
		endcase
	endfunction

	function automatic rgb_t model_rgb(int col, int row);
		bit fld;
		int fs;
		int dig;
		fld = 0;
		fs  = 0;
		dig = 0;
		if (row < 30)
		begin
			if (!m_two && col >= 520)
			begin
				fld = 1;
				fs  = 520 + ((col - 520) / 30) * 30;
				dig = m_p1[(col - 520) / 30];
			end
			else if (m_two && col >= 120 && col < 210)
			begin
				fld = 1;
				fs  = 120 + ((col - 120) / 30) * 30;
				dig = m_p1[1 + (col - 120) / 30];
			end
			else if (m_two && col >= 430 && col < 520)
			begin
				fld = 1;
				fs  = 430 + ((col - 430) / 30) * 30;
				dig = m_p2[(col - 430) / 30];
			end
		end
		if (fld && seg_hit(dig, col - fs, row))
			return 24'hFFFFFF;
		if (in_box(col, row, 10, 109, 10, 109))
			return crest_rgb(m_h1);
		if (m_two && in_box(col, row, 530, 629, 10, 109))
			return crest_rgb(m_h2);
		if (in_box(col, row, 120, 519, 40, 439))
			return 24'h808080;
		return bg_rgb(m_h1);
	endfunction

	//////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////

	task automatic drive_settings(int scn, int two, int h1, int h2, int th, int hu, int te,
		int on, int q2h, int q2t, int q2o);
		two_player_mode = two[0];
		house_p1        = house_t'(h1[1:0]);
		house_p2        = house_t'(h2[1:0]);
		p1_thousands    = bcd_digit_t'(th[3:0]);
		p1_hundreds     = bcd_digit_t'(hu[3:0]);
		p1_tens         = bcd_digit_t'(te[3:0]);
		p1_ones         = bcd_digit_t'(on[3:0]);
		p2_hundreds     = bcd_digit_t'(q2h[3:0]);
		p2_tens         = bcd_digit_t'(q2t[3:0]);
		p2_ones         = bcd_digit_t'(q2o[3:0]);
		pend_scn        = scn;
		pend_two        = two;
		pend_h1         = h1;
		pend_h2         = h2;
		pend_p1         = '{th, hu, te, on};
		pend_p2         = '{q2h, q2t, q2o};
	endtask

	task automatic drive_scenario(int s);
		drive_settings(s, sc_val[s][0], sc_val[s][1], sc_val[s][2], sc_val[s][3],
			sc_val[s][4], sc_val[s][5], sc_val[s][6], sc_val[s][7], sc_val[s][8],
			sc_val[s][9]);
	endtask

	task automatic load_testdata();
		int fd;
		int r;
		int col;
		int row;
		rgb_t exp;
		logic [8*8-1:0] tag;
		logic [8*200-1:0] rest;
		fd = $fopen("test/screen_testdata.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the test data file");
			err_other++;
			return;
		end
		while (!$feof(fd))
		begin
			r = $fscanf(fd, " %s", tag);
			if (r != 1)
				break;
			if (tag == "#")
				r = $fgets(rest, fd);
			else if (tag == "S")
			begin
				r = $fscanf(fd, " %d %d %d %d %d %d %d %d %d %d", sc_val[n_scn][0],
					sc_val[n_scn][1], sc_val[n_scn][2], sc_val[n_scn][3], sc_val[n_scn][4],
					sc_val[n_scn][5], sc_val[n_scn][6], sc_val[n_scn][7], sc_val[n_scn][8],
					sc_val[n_scn][9]);
				n_scn++;
			end
			else if (tag == "P")
			begin
				r = $fscanf(fd, " %d %d %h", col, row, exp);
				p_scn.push_back(n_scn - 1);
				p_col.push_back(col);
				p_row.push_back(row);
				p_rgb.push_back(exp);
				p_seen.push_back(1'b0);
			end
		end
		$fclose(fd);
	endtask

	// returns just after the rising edge of oVS in vertical blanking
	task automatic wait_frame_start(output bit ok);
		logic w_prev;
		w_prev = oVS;
		ok = 0;
		for (int n = 0; n < frame_cycles + 800 && !ok; n++)
		begin
			@(negedge iVGA_CLK);
			if (oVS && !w_prev)
				ok = 1;
			w_prev = oVS;
		end
		if (ok)
		begin
			@(posedge iVGA_CLK);
			#5;
		end
	endtask

	//////////////////////////////////////////////////
	// port monitor sampled mid cycle
	//////////////////////////////////////////////////

	always @(negedge iVGA_CLK)
	begin
		if (iRST_n)
		begin
			pix = {r_data, g_data, b_data};
			if (oVS && !vs_prev)
			begin
				if (frames_seen > 0)
				begin
					check_count(fc_cycles, frame_cycles, "cycles per frame");
					check_count(fc_hs_low, 96 * 525, "hs low cycles per frame");
					check_count(fc_vs_low, 2 * 800, "vs low cycles per frame");
					check_count(fc_blank, 640 * 480, "visible cycles per frame");
				end
				frames_seen++;
				fc_cycles = 0;
				fc_hs_low = 0;
				fc_vs_low = 0;
				fc_blank  = 0;
				mon_row   = 0;
				mon_col   = 0;
				new_frame = 1;
			end
			fc_cycles++;
			if (!oHS)
				fc_hs_low++;
			if (!oVS)
				fc_vs_low++;
			if (oBLANK_n)
				fc_blank++;

			// line period and hs width
			if (!oHS)
				hs_run++;
			if (oHS && !hs_prev)
			begin
				check_count(hs_run, 96, "hs low pulse width");
				hs_run = 0;
			end
			if (!oHS && hs_prev)
			begin
				if (hs_gap > 0)
					check_count(hs_gap, 800, "hs period");
				hs_gap = 0;
			end
			if (hs_gap >= 0)
				hs_gap++;

			if (blank_prev && !oBLANK_n)
			begin
				mon_col = 0;
				mon_row++;
			end

			if (!oBLANK_n)
				check_rgb(pix, 24'h000000, "colour while blanked");
			else
			begin
				if (new_frame)
				begin
					cur_scn   = pend_scn;
					m_two     = pend_two;
					m_h1      = pend_h1;
					m_h2      = pend_h2;
					m_p1      = pend_p1;
					m_p2      = pend_p2;
					new_frame = 0;
				end
				for (int i = 0; i < p_col.size(); i++)
				begin
					if (p_scn[i] == cur_scn && p_col[i] == mon_col && p_row[i] == mon_row)
					begin
						// a scenario can stay on screen for more than one frame
						if (!p_seen[i])
						begin
							p_seen[i] = 1'b1;
							probe_hits++;
						end
						check_rgb(pix, p_rgb[i], $sformatf("probe (%0d,%0d) scenario %0d",
							mon_col, mon_row, cur_scn));
					end
				end
				if ((mon_col == 0 && mon_row == 0) || $urandom_range(0, 15) == 0)
					check_rgb(pix, model_rgb(mon_col, mon_row),
						$sformatf("pixel (%0d,%0d) against model", mon_col, mon_row));
				mon_col++;
			end
			blank_prev = oBLANK_n;
			hs_prev    = oHS;
			vs_prev    = oVS;
		end
	end

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial
	begin
		bit ok;
		int n;
		void'($urandom(32'h4cb9));
		iVGA_CLK    = 1'b0;
		iRST_n      = 1'b0;
		err_value   = 0;
		err_other   = 0;
		n_scn       = 0;
		probe_hits  = 0;
		mon_col     = 0;
		mon_row     = 0;
		new_frame   = 1;
		blank_prev  = 1'b0;
		hs_prev     = 1'b1;
		vs_prev     = 1'b1;
		hs_run      = 0;
		hs_gap      = -1;
		frames_seen = 0;
		fc_cycles   = 0;
		fc_hs_low   = 0;
		fc_vs_low   = 0;
		fc_blank    = 0;
		drive_settings(-1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		load_testdata();

		repeat (9) @(posedge iVGA_CLK);
		@(negedge iVGA_CLK);
		check_level(oHS, 1'b1, "hs during reset");
		check_level(oVS, 1'b1, "vs during reset");
		check_level(oBLANK_n, 1'b0, "blank_n during reset");
		check_rgb({r_data, g_data, b_data}, 24'h000000, "colour during reset");
		@(posedge iVGA_CLK);
		#5;
		iRST_n = 1'b1;

		// frame 0 runs on reset defaults
		wait_frame_start(ok);
		if (ok)
		begin
			drive_scenario(0);
			wait_frame_start(ok);
		end
		if (ok)
		begin
			drive_scenario(1);
			wait_frame_start(ok);
		end
		// change everything half way down the frame
		if (ok)
		begin
			n = 0;
			while (mon_row < 240 && n < frame_cycles)
			begin
				@(posedge iVGA_CLK);
				n++;
			end
			#5;
			drive_settings(2, $urandom_range(0, 1), $urandom_range(0, 3), $urandom_range(0, 3),
				$urandom_range(0, 15), $urandom_range(0, 15), $urandom_range(0, 15),
				$urandom_range(0, 15), $urandom_range(0, 15), $urandom_range(0, 15),
				$urandom_range(0, 15));
			wait_frame_start(ok);
		end
		if (ok)
			wait_frame_start(ok);

		if (!ok)
		begin
			$display("no rising edge of vertical sync within one frame time");
			err_other++;
		end
		if (probe_hits != p_col.size())
		begin
			$display("only %0d of %0d probe points were reached", probe_hits, p_col.size());
			err_other++;
		end
		$display("value errors: %0d, other errors: %0d", err_value, err_other);
		if (err_value == 0 && err_other == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// watchdog sized on the frame count
	initial
	begin
		#(64'd100 * max_frames * frame_cycles);
		$display("run did not finish within %0d frames", max_frames);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
